//--- logic/xmit_pkg.sv
package xmit_pkg;

    // data byte and frame buffer address
    typedef logic [7:0] byte_t;
    typedef logic [8:0] buf_addr_t;

    // frame type codes from the host
    // raw: no crc, no ack
    localparam byte_t ftype_raw = 8'h30;
    // data: crc, no ack
    localparam byte_t ftype_data = 8'h31;
    // ack request: crc and wait for ack
    localparam byte_t ftype_ack_req = 8'h32;

    // fixed frame bytes
    localparam byte_t preamble_byte = 8'h55;
    localparam byte_t sfd_byte = 8'hD0;

    // payload bytes per frame, at most
    localparam int max_payload = 255;

    // crc-8, msb first, start value zero
    localparam byte_t crc_poly = 8'h07;

    // one frame held in the buffer, passed down the pipeline
    typedef struct packed {
        buf_addr_t last_addr;
        logic      need_ack;
    } frame_desc_t;

    // sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_fetch,
        seq_present,
        seq_ack_wait,
        seq_finish
    } seq_state_t;

endpackage

//--- logic/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer (
    input  logic                clk,
    input  logic                wr_en,
    input  xmit_pkg::buf_addr_t wr_addr,
    input  xmit_pkg::byte_t     wr_data,
    input  logic                rd_en,
    input  xmit_pkg::buf_addr_t rd_addr,
    output xmit_pkg::byte_t     rd_data
);
    import xmit_pkg::*;

    // one word per buffer address
    localparam int depth = 2 ** $bits(buf_addr_t);

    byte_t mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after rd_en
    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- logic/frame_builder.sv
`timescale 1ns/10ps

module frame_builder #(
    parameter int preamble_len = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  xvalid,
    input  xmit_pkg::byte_t       xdata,
    input  logic                  xsend,
    input  xmit_pkg::byte_t       mac,
    input  logic                  frame_done,
    output logic                  xrdy,
    output logic                  wr_en,
    output xmit_pkg::buf_addr_t   wr_addr,
    output xmit_pkg::byte_t       wr_data,
    output logic                  frame_ready,
    output xmit_pkg::frame_desc_t desc
);
    import xmit_pkg::*;

    // fixed layout: preamble, sfd, dest, own address, type, payload
    localparam buf_addr_t sfd_addr = buf_addr_t'(preamble_len);
    localparam buf_addr_t dest_addr = buf_addr_t'(preamble_len + 1);
    localparam buf_addr_t src_addr = buf_addr_t'(preamble_len + 2);
    localparam buf_addr_t type_addr = buf_addr_t'(preamble_len + 3);
    localparam buf_addr_t pay_base = buf_addr_t'(preamble_len + 4);
    localparam buf_addr_t pay_max = buf_addr_t'(max_payload);

    typedef enum logic [3:0] {
        s_dest,
        s_pre,
        s_sfd,
        s_src,
        s_type,
        s_payload,
        s_crc,
        s_ready,
        s_hold
    } build_state_t;

    build_state_t state;
    buf_addr_t    pre_cnt;
    buf_addr_t    len;
    buf_addr_t    pay_addr;
    byte_t        crc;
    byte_t        type_q;
    logic         has_crc;
    logic         pay_take;

    function automatic byte_t crc8_next(input byte_t crc_in, input byte_t data);
        byte_t c;
        c = crc_in ^ data;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ crc_poly) : (c << 1);
        end
        return c;
    endfunction

    assign pay_addr = pay_base + len;
    assign has_crc = type_q != ftype_raw;
    // 256th byte is taken but only closes the frame
    assign pay_take = xvalid && (len != pay_max);

    assign xrdy = (state == s_dest) || (state == s_type) || (state == s_payload);
    assign frame_ready = state == s_ready;

    always_comb begin
        wr_en = 1'b0;
        wr_addr = dest_addr;
        wr_data = xdata;
        case (state)
            s_dest: wr_en = xvalid;
            s_pre: begin
                wr_en = 1'b1;
                wr_addr = pre_cnt;
                wr_data = preamble_byte;
            end
            s_sfd: begin
                wr_en = 1'b1;
                wr_addr = sfd_addr;
                wr_data = sfd_byte;
            end
            s_src: begin
                wr_en = 1'b1;
                wr_addr = src_addr;
                wr_data = mac;
            end
            s_type: begin
                wr_en = xvalid;
                wr_addr = type_addr;
            end
            s_payload: begin
                wr_en = pay_take;
                wr_addr = pay_addr;
            end
            s_crc: begin
                wr_en = has_crc;
                wr_addr = pay_addr;
                wr_data = crc;
            end
            default: wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_dest;
            pre_cnt <= '0;
            len <= '0;
        end else begin
            case (state)
                s_dest: if (xvalid) begin
                    state <= s_pre;
                    pre_cnt <= '0;
                    len <= '0;
                end
                s_pre: begin
                    pre_cnt <= pre_cnt + 1'b1;
                    if (pre_cnt == sfd_addr - 1'b1) state <= s_sfd;
                end
                s_sfd: state <= s_src;
                s_src: state <= s_type;
                // xsend before the type byte is ignored
                s_type: if (xvalid) state <= s_payload;
                s_payload: begin
                    if (xvalid && !pay_take) begin
                        state <= s_crc;
                    end else begin
                        if (xvalid) len <= len + 1'b1;
                        if (xsend) state <= s_crc;
                    end
                end
                s_crc: state <= s_ready;
                s_ready: state <= s_hold;
                s_hold: if (frame_done) state <= s_dest;
                default: state <= s_dest;
            endcase
        end
    end

    // running crc over dest, own address, type and payload
    always_ff @(posedge clk) begin
        case (state)
            s_dest: if (xvalid) crc <= crc8_next('0, xdata);
            s_src: crc <= crc8_next(crc, mac);
            s_type: if (xvalid) begin
                crc <= crc8_next(crc, xdata);
                type_q <= xdata;
            end
            s_payload: if (pay_take) crc <= crc8_next(crc, xdata);
            s_crc: begin
                desc.last_addr <= has_crc ? pay_addr : pay_addr - 1'b1;
                desc.need_ack <= type_q == ftype_ack_req;
            end
            default: crc <= crc;
        endcase
    end

endmodule

//--- logic/medium_access.sv
`timescale 1ns/10ps

module medium_access #(
    parameter int difs_cycles = 80,
    parameter int slot_cycles = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cardet,
    input  logic                  frame_ready,
    input  logic                  retry_req,
    input  xmit_pkg::frame_desc_t desc_in,
    output logic                  grant,
    output xmit_pkg::frame_desc_t desc_out
);
    import xmit_pkg::*;

    localparam logic [15:0] difs_last = 16'(difs_cycles - 1);

    typedef enum logic [1:0] {
        ma_idle,
        ma_difs,
        ma_backoff,
        ma_grant
    } ma_state_t;

    ma_state_t   state;
    logic [15:0] lfsr;
    logic [15:0] cnt;
    logic [15:0] backoff_len;
    logic        busy_seen;
    frame_desc_t desc_q;

    assign grant = state == ma_grant;
    assign desc_out = desc_q;

    // free running, taps 16 14 13 11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // descriptor kept for retries
    always_ff @(posedge clk) begin
        if (frame_ready) desc_q <= desc_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ma_idle;
            cnt <= '0;
            busy_seen <= 1'b0;
        end else begin
            case (state)
                ma_idle: if (frame_ready || retry_req) begin
                    state <= ma_difs;
                    cnt <= '0;
                    busy_seen <= 1'b0;
                end
                ma_difs: begin
                    if (cardet) begin
                        busy_seen <= 1'b1;
                        cnt <= '0;
                    end else if (cnt == difs_last) begin
                        cnt <= '0;
                        if (busy_seen) begin
                            // 1 to 64 slots
                            state <= ma_backoff;
                            backoff_len <= 16'((lfsr[5:0] + 7'd1) * slot_cycles);
                        end else begin
                            state <= ma_grant;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ma_backoff: begin
                    // carrier during backoff restarts the whole wait
                    if (cardet) begin
                        state <= ma_difs;
                        cnt <= '0;
                    end else if (cnt == backoff_len - 1'b1) begin
                        state <= ma_grant;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ma_grant: state <= ma_idle;
                default: state <= ma_idle;
            endcase
        end
    end

endmodule

//--- logic/xmit_sequencer.sv
`timescale 1ns/10ps

module xmit_sequencer #(
    parameter int ack_timeout = 256,
    parameter int max_attempts = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  grant,
    input  xmit_pkg::frame_desc_t desc,
    input  xmit_pkg::byte_t       rd_data,
    input  logic                  mx_rdy,
    input  logic                  ack_received,
    output logic                  rd_en,
    output xmit_pkg::buf_addr_t   rd_addr,
    output logic                  mx_valid,
    output xmit_pkg::byte_t       mx_data,
    output logic                  xbusy,
    output logic                  retry_req,
    output logic                  frame_done,
    output xmit_pkg::byte_t       xerrcnt
);
    import xmit_pkg::*;

    localparam int att_w = $clog2(max_attempts + 1);
    localparam int tmo_w = $clog2(ack_timeout + 1);

    seq_state_t       state;
    frame_desc_t      desc_q;
    buf_addr_t        addr;
    logic [att_w-1:0] attempt;
    logic [tmo_w-1:0] timer;
    logic             timed_out;
    logic             last_try;

    assign timed_out = timer == tmo_w'(ack_timeout - 1);
    assign last_try = attempt == att_w'(max_attempts);

    assign rd_en = state == seq_fetch;
    assign rd_addr = addr;
    // buffer output holds while presenting
    assign mx_valid = state == seq_present;
    assign mx_data = rd_data;
    // attempt is nonzero for the whole frame, retries included
    assign xbusy = attempt != '0;
    assign frame_done = state == seq_finish;
    assign retry_req = (state == seq_ack_wait) && !ack_received && timed_out && !last_try;

    always_ff @(posedge clk) begin
        if (grant) desc_q <= desc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seq_idle;
            addr <= '0;
            attempt <= '0;
            timer <= '0;
            xerrcnt <= '0;
        end else begin
            case (state)
                seq_idle: if (grant) begin
                    state <= seq_fetch;
                    addr <= '0;
                    attempt <= attempt + 1'b1;
                end
                seq_fetch: state <= seq_present;
                seq_present: if (mx_rdy) begin
                    if (addr == desc_q.last_addr) begin
                        timer <= '0;
                        state <= desc_q.need_ack ? seq_ack_wait : seq_finish;
                    end else begin
                        addr <= addr + 1'b1;
                        state <= seq_fetch;
                    end
                end
                seq_ack_wait: begin
                    if (ack_received) begin
                        state <= seq_finish;
                    end else if (timed_out) begin
                        if (last_try) begin
                            // give up, count the lost frame
                            state <= seq_finish;
                            if (xerrcnt != '1) xerrcnt <= xerrcnt + 1'b1;
                        end else begin
                            // medium access runs the wait again
                            state <= seq_idle;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                seq_finish: begin
                    state <= seq_idle;
                    attempt <= '0;
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

//--- logic/xmit_top.sv
`timescale 1ns/10ps

module xmit_top #(
    parameter int preamble_len = 2,
    parameter int difs_cycles = 80,
    parameter int slot_cycles = 8,
    parameter int ack_timeout = 256,
    parameter int max_attempts = 5
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            xvalid,
    input  xmit_pkg::byte_t xdata,
    input  logic            xsend,
    input  xmit_pkg::byte_t mac,
    input  logic            cardet,
    input  logic            mx_rdy,
    input  logic            ack_received,
    output logic            xrdy,
    output logic            xbusy,
    output logic            mx_valid,
    output xmit_pkg::byte_t mx_data,
    output xmit_pkg::byte_t xerrcnt
);
    import xmit_pkg::*;

    // builder to buffer
    logic        wr_en;
    buf_addr_t   wr_addr;
    byte_t       wr_data;
    // sequencer to buffer
    logic        rd_en;
    buf_addr_t   rd_addr;
    byte_t       rd_data;
    // stage handoffs
    logic        frame_ready;
    logic        frame_done;
    logic        grant;
    logic        retry_req;
    frame_desc_t build_desc;
    frame_desc_t grant_desc;

    frame_builder #(
        .preamble_len(preamble_len)
    ) u_builder (
        .clk(clk), .rst(rst),
        .xvalid(xvalid), .xdata(xdata), .xsend(xsend), .mac(mac),
        .frame_done(frame_done), .xrdy(xrdy),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .frame_ready(frame_ready), .desc(build_desc)
    );

    frame_buffer u_buffer (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    medium_access #(
        .difs_cycles(difs_cycles),
        .slot_cycles(slot_cycles)
    ) u_access (
        .clk(clk), .rst(rst), .cardet(cardet),
        .frame_ready(frame_ready), .retry_req(retry_req), .desc_in(build_desc),
        .grant(grant), .desc_out(grant_desc)
    );

    xmit_sequencer #(
        .ack_timeout(ack_timeout),
        .max_attempts(max_attempts)
    ) u_sequencer (
        .clk(clk), .rst(rst),
        .grant(grant), .desc(grant_desc), .rd_data(rd_data),
        .mx_rdy(mx_rdy), .ack_received(ack_received),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .mx_valid(mx_valid), .mx_data(mx_data),
        .xbusy(xbusy), .retry_req(retry_req), .frame_done(frame_done),
        .xerrcnt(xerrcnt)
    );

endmodule

//--- sim/xmit_assert.sv
`timescale 1ns/10ps

module xmit_assert (
    input logic                 clk,
    input logic                 rst,
    input xmit_pkg::seq_state_t state,
    input logic                 mx_valid,
    input logic                 mx_rdy,
    input xmit_pkg::byte_t      mx_data,
    input xmit_pkg::byte_t      xerrcnt
);
    import xmit_pkg::*;

    int fail_count = 0;

    // byte held until the encoder takes it
    property data_held;
        @(posedge clk) disable iff (rst)
            (mx_valid && !mx_rdy) |=> (mx_valid && $stable(mx_data));
    endproperty

    // idle always goes through a fetch before a byte is shown
    property quiet_when_idle;
        @(posedge clk) disable iff (rst) (state == seq_idle) |=> !mx_valid;
    endproperty

    // saturating counter, never wraps
    property errcnt_monotonic;
        @(posedge clk) disable iff (rst) xerrcnt >= $past(xerrcnt);
    endproperty

    data_held_a: assert property (data_held) else begin
        $error("mx_data changed or mx_valid dropped before the handshake");
        fail_count++;
    end

    quiet_when_idle_a: assert property (quiet_when_idle) else begin
        $error("mx_valid high in or right after the idle state");
        fail_count++;
    end

    errcnt_monotonic_a: assert property (errcnt_monotonic) else begin
        $error("xerrcnt decreased");
        fail_count++;
    end

endmodule

bind xmit_sequencer xmit_assert i_assert (
    .clk(clk), .rst(rst), .state(state),
    .mx_valid(mx_valid), .mx_rdy(mx_rdy), .mx_data(mx_data),
    .xerrcnt(xerrcnt)
);

//--- sim/xmit_tb.sv
`timescale 1ns/10ps

module xmit_tb;
    import xmit_pkg::*;

    localparam int preamble_len = 2;
    localparam int difs_cycles = 80;
    localparam int slot_cycles = 8;
    localparam int ack_timeout = 256;
    localparam int max_attempts = 5;
    localparam byte_t mac_addr = 8'hc4;

    // one line of the input file
    typedef struct packed {
        byte_t       dest;
        byte_t       ftype;
        logic [15:0] len;
        logic [31:0] seed;
        logic        carrier;
        logic [7:0]  withhold;
        logic [7:0]  sends;
        logic [7:0]  errs;
    } test_t;

    logic  clk;
    logic  rst;
    logic  xvalid;
    byte_t xdata;
    logic  xsend;
    byte_t mac;
    logic  cardet;
    logic  mx_rdy;
    logic  ack_received;
    logic  xrdy;
    logic  xbusy;
    logic  mx_valid;
    byte_t mx_data;
    byte_t xerrcnt;

    test_t       tests[$];
    string       test_names[$];
    byte_t       exp_bytes[$];
    byte_t       payload[$];
    string       cur_name = "reset";
    logic        cur_need_ack = 1'b0;
    int          cur_withhold = 0;
    int          cur_sends = 0;
    int          sends = 0;
    int          byte_idx = 0;
    int          ack_delay = 0;
    int          exp_errcnt = 0;
    int          limit_cycles = 0;
    logic [31:0] rdy_rng = 32'h0a59_7a73;

    xmit_top #(
        .preamble_len(preamble_len),
        .difs_cycles(difs_cycles),
        .slot_cycles(slot_cycles),
        .ack_timeout(ack_timeout),
        .max_attempts(max_attempts)
    ) i_dut (
        .clk(clk), .rst(rst),
        .xvalid(xvalid), .xdata(xdata), .xsend(xsend), .mac(mac),
        .cardet(cardet), .mx_rdy(mx_rdy), .ack_received(ack_received),
        .xrdy(xrdy), .xbusy(xbusy),
        .mx_valid(mx_valid), .mx_data(mx_data), .xerrcnt(xerrcnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit serial form, data shifted in msb first
    function automatic byte_t crc8_shift(input byte_t crc_in, input byte_t data);
        byte_t c;
        logic  fb;
        int    k;
        c = crc_in;
        for (k = 7; k >= 0; k--) begin
            fb = c[7] ^ data[k];
            c = {c[6:0], 1'b0};
            if (fb) c = c ^ crc_poly;
        end
        return c;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("** Error %s %s: expected 0x%0h, actual 0x%0h",
                cur_name, what, expected, actual));
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        string name;
        int    dest;
        int    ftype;
        int    len;
        int    seed;
        int    carrier;
        int    withhold;
        int    n_sends;
        int    n_errs;
        test_t t;
        fd = $fopen("sim/xmit_input.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open sim/xmit_input.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // skip blank and comment lines
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %d %h %d %d %d %d", name, dest, ftype,
                        len, seed, carrier, withhold, n_sends, n_errs);
                    if (n == 9) begin
                        t.dest = byte_t'(dest);
                        t.ftype = byte_t'(ftype);
                        t.len = 16'(len);
                        t.seed = 32'(seed);
                        t.carrier = carrier != 0;
                        t.withhold = 8'(withhold);
                        t.sends = 8'(n_sends);
                        t.errs = 8'(n_errs);
                        tests.push_back(t);
                        test_names.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // payload from the seed, then the frame as it must appear on the line
    task automatic build_frame(input test_t t);
        logic [31:0] rng;
        byte_t       crc;
        int          n_pay;
        int          i;
        exp_bytes.delete();
        payload.delete();
        rng = 32'h0a59_7a73 ^ t.seed;
        for (i = 0; i < t.len; i++) begin
            rng = xorshift(rng);
            payload.push_back(rng[7:0]);
        end
        n_pay = (t.len > max_payload) ? max_payload : t.len;
        for (i = 0; i < preamble_len; i++) exp_bytes.push_back(preamble_byte);
        exp_bytes.push_back(sfd_byte);
        exp_bytes.push_back(t.dest);
        exp_bytes.push_back(mac_addr);
        exp_bytes.push_back(t.ftype);
        for (i = 0; i < n_pay; i++) exp_bytes.push_back(payload[i]);
        if (t.ftype != ftype_raw) begin
            // covers dest through last payload byte
            crc = '0;
            for (i = preamble_len + 1; i < exp_bytes.size(); i++) begin
                crc = crc8_shift(crc, exp_bytes[i]);
            end
            exp_bytes.push_back(crc);
        end
    endtask

    task automatic offer_byte(input byte_t b);
        while (!xrdy) begin
            @(posedge clk);
            #10;
        end
        xvalid = 1'b1;
        xdata = b;
        @(posedge clk);
        #10;
        xvalid = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_t t;
        int    i;
        t = tests[idx];
        cur_name = test_names[idx];
        build_frame(t);
        cur_need_ack = t.ftype == ftype_ack_req;
        cur_withhold = t.withhold;
        cur_sends = t.sends;
        sends = 0;
        byte_idx = 0;
        // error counter saturates at 255
        exp_errcnt = (exp_errcnt + t.errs > 255) ? 255 : exp_errcnt + t.errs;
        if (t.carrier) cardet = 1'b1;
        offer_byte(t.dest);
        offer_byte(t.ftype);
        for (i = 0; i < t.len; i++) begin
            if (i <= max_payload) begin
                offer_byte(payload[i]);
            end else begin
                // frame already closed by the 256th byte
                check("xrdy after cut", 0, xrdy);
                xvalid = 1'b1;
                xdata = payload[i];
                @(posedge clk);
                #10;
                xvalid = 1'b0;
            end
        end
        if (t.len <= max_payload) begin
            xsend = 1'b1;
            @(posedge clk);
            #10;
            xsend = 1'b0;
        end
        check("xrdy after close", 0, xrdy);
        if (t.carrier) begin
            repeat (150) begin
                @(posedge clk);
                #10;
            end
            cardet = 1'b0;
        end
        while (sends < t.sends || !xrdy) begin
            @(posedge clk);
            #10;
        end
        repeat (20) begin
            @(posedge clk);
            #10;
        end
        check("transmissions", t.sends, sends);
        check("error count", exp_errcnt, xerrcnt);
        check("xrdy at end", 1, xrdy);
        check("xbusy at end", 0, xbusy);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // line encoder and ack source
    always @(posedge clk) begin
        #10;
        rdy_rng = xorshift(rdy_rng);
        mx_rdy = rdy_rng[1:0] != 2'b00;
        ack_received = 1'b0;
        if (ack_delay != 0) begin
            ack_delay = ack_delay - 1;
            if (ack_delay == 0) ack_received = 1'b1;
        end
    end

    // output bytes are stable at the falling edge
    always @(negedge clk) begin
        if (i_dut.u_sequencer.i_assert.fail_count != 0) begin
            stop_with_failure("a protocol assertion on the sequencer failed");
        end else if (!rst && mx_valid && mx_rdy) begin
            if (cardet) begin
                stop_with_failure({"test ", cur_name,
                    ": a byte was handed over while carrier detect was high"});
            end else if (sends >= cur_sends) begin
                stop_with_failure({"test ", cur_name,
                    ": the frame was sent more often than expected"});
            end else begin
                check("xbusy while sending", 1, xbusy);
                check($sformatf("byte %0d of send %0d", byte_idx, sends + 1),
                    exp_bytes[byte_idx], mx_data);
                byte_idx++;
                if (byte_idx == exp_bytes.size()) begin
                    byte_idx = 0;
                    sends++;
                    if (cur_need_ack && sends > cur_withhold) ack_delay = 4;
                end
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout: tests still running after %0d cycles",
            limit_cycles));
    end

    initial begin
        int i;
        int total;
        rst = 1'b1;
        xvalid = 1'b0;
        xdata = '0;
        xsend = 1'b0;
        mac = mac_addr;
        cardet = 1'b0;
        mx_rdy = 1'b0;
        ack_received = 1'b0;
        read_tests();
        if (tests.size() == 0) begin
            stop_with_failure("no tests found in sim/xmit_input.txt");
        end else begin
            // 2000 cycles per test and per retry
            total = 0;
            for (i = 0; i < tests.size(); i++) begin
                total = total + 2000 + 2000 * (tests[i].sends - 1);
            end
            limit_cycles = total;
            repeat (4) @(posedge clk);
            #10;
            rst = 1'b0;
            for (i = 0; i < tests.size(); i++) run_test(i);
            repeat (5) @(posedge clk);
            if (i_dut.u_sequencer.i_assert.fail_count == 0) begin
                $display("RESULT: PASS");
                $finish;
            end else begin
                stop_with_failure("a protocol assertion on the sequencer failed");
            end
        end
    end

endmodule

//--- sim/xmit_input.txt
# name dest type len seed carrier withhold sends errs
# dest, type and seed in hex; len, carrier, withhold, sends and errs in decimal
data_frame   a7 31 16  11 0 0 1 0
raw_short    3c 30 9   27 0 0 1 0
raw_cut      3c 30 300 22 0 0 1 0
carrier_busy 5e 31 24  33 1 0 1 0
ack_first    81 32 12  44 0 0 1 0
ack_lost     92 32 8   55 0 9 5 1
after_lost   a7 31 20  66 0 0 1 0
other_type   4b 7f 5   77 0 0 1 0

//--- sim.f
logic/xmit_pkg.sv
logic/frame_buffer.sv
logic/frame_builder.sv
logic/medium_access.sv
logic/xmit_sequencer.sv
logic/xmit_top.sv
sim/xmit_assert.sv
sim/xmit_tb.sv

//--- Bender.yml
package:
  name: xmit_mac

sources:
  - logic/xmit_pkg.sv
  - logic/frame_buffer.sv
  - logic/frame_builder.sv
  - logic/medium_access.sv
  - logic/xmit_sequencer.sv
  - logic/xmit_top.sv
  - target: simulation
    files:
      - sim/xmit_assert.sv
      - sim/xmit_tb.sv
